// File: rn_reg_pkg.sv
// Shared bus widths, register map, write and read FSM state encodings and the OKAY code
package rn_reg_pkg;

  // ==================================================================
  // Bus widths
  // ==================================================================

  // Byte address width of the AXI-Lite register port
  localparam int axil_addr_w = 12;

  // Width of every register word and of the data channels
  localparam int axil_data_w = 32;

  // Only response ever returned on B and R
  localparam logic [1:0] axil_resp_okay = 2'b00;

  // ==================================================================
  // Register map
  // ==================================================================

  // Byte offsets of the mapped registers
  // Counter words are cleared when read
  typedef enum logic [axil_addr_w-1:0] {
    reg_version      = 12'h000,
    reg_fatal_err    = 12'h004,
    reg_roce_high    = 12'h008,
    reg_roce_low     = 12'h00C,
    reg_nonroce_high = 12'h018,
    reg_nonroce_low  = 12'h01C,
    reg_template     = 12'h200
  } reg_addr_e;

  // ==================================================================
  // FSM states
  // ==================================================================

  // Write engine, one write in flight at a time
  typedef enum logic [1:0] {
    wr_idle      = 2'd0,
    wr_wait_data = 2'd1,
    wr_resp      = 2'd2
  } wr_state_e;

  // Read engine, one read in flight at a time
  typedef enum logic [0:0] {
    rd_idle = 1'b0,
    rd_resp = 1'b1
  } rd_state_e;

endpackage

// File: rn_axil_write.sv
// AXI-Lite write channel FSM with the read/write template register
module rn_axil_write
  import rn_reg_pkg::*;
(
  input  logic                   axil_aclk,
  input  logic                   axil_arstn,

  // AW channel
  input  logic                   s_axil_reg_awvalid,
  input  logic [axil_addr_w-1:0] s_axil_reg_awaddr,
  output logic                   s_axil_reg_awready,

  // W channel
  input  logic                   s_axil_reg_wvalid,
  input  logic [axil_data_w-1:0] s_axil_reg_wdata,
  output logic                   s_axil_reg_wready,

  // B channel
  output logic                   s_axil_reg_bvalid,
  output logic [1:0]             s_axil_reg_bresp,
  input  logic                   s_axil_reg_bready,

  // Template register contents, read back through the read engine
  output logic [axil_data_w-1:0] template_value
);

  wr_state_e              wr_state;
  logic [axil_addr_w-1:0] awaddr_q;
  logic [axil_addr_w-1:0] wr_addr;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;

  // ==================================================================
  // Handshake decode
  // ==================================================================

  // Address accepted only while no write is in flight
  assign s_axil_reg_awready = (wr_state == wr_idle);

  // Data taken with the address when both show up together,
  // otherwise in the cycle after the address handshake
  assign s_axil_reg_wready  = ((wr_state == wr_idle) && s_axil_reg_awvalid && s_axil_reg_wvalid)
                              || (wr_state == wr_wait_data);

  // Response held until the master takes it
  assign s_axil_reg_bvalid  = (wr_state == wr_resp);
  assign s_axil_reg_bresp   = axil_resp_okay;

  assign aw_fire = s_axil_reg_awvalid && s_axil_reg_awready;
  assign w_fire  = s_axil_reg_wvalid && s_axil_reg_wready;
  assign b_fire  = s_axil_reg_bvalid && s_axil_reg_bready;

  // Target address: live bus in idle, latched copy while waiting for data
  assign wr_addr = (wr_state == wr_idle) ? s_axil_reg_awaddr : awaddr_q;

  // ==================================================================
  // Write FSM
  // ==================================================================

  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      wr_state <= wr_idle;
    end
    else
    begin
      case (wr_state)
        wr_idle:
        begin
          // Skip the data wait when W came along with AW
          if (aw_fire)
          begin
            wr_state <= w_fire ? wr_resp : wr_wait_data;
          end
        end
        wr_wait_data:
        begin
          if (w_fire)
          begin
            wr_state <= wr_resp;
          end
        end
        wr_resp:
        begin
          if (b_fire)
          begin
            wr_state <= wr_idle;
          end
        end
        default:
        begin
          wr_state <= wr_idle;
        end
      endcase
    end
  end

  // Hold the address while W is outstanding
  always_ff @(posedge axil_aclk)
  begin
    if (aw_fire)
    begin
      awaddr_q <= s_axil_reg_awaddr;
    end
  end

  // Template register, other offsets are silently dropped
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      template_value <= '0;
    end
    else if (w_fire && (wr_addr == reg_template))
    begin
      template_value <= s_axil_reg_wdata;
    end
  end

endmodule

// File: rn_axil_read.sv
// AXI-Lite read channel FSM with address decode, read-data mux and clear-on-read pulses
module rn_axil_read
  import rn_reg_pkg::*;
#(
  // Word returned for offsets outside the register map
  parameter logic [axil_data_w-1:0] default_value = 32'hDEEDBEEF
)(
  input  logic                   axil_aclk,
  input  logic                   axil_arstn,

  // AR channel
  input  logic                   s_axil_reg_arvalid,
  input  logic [axil_addr_w-1:0] s_axil_reg_araddr,
  output logic                   s_axil_reg_arready,

  // R channel
  output logic                   s_axil_reg_rvalid,
  output logic [axil_data_w-1:0] s_axil_reg_rdata,
  output logic [1:0]             s_axil_reg_rresp,
  input  logic                   s_axil_reg_rready,

  // Register sources
  input  logic [axil_data_w-1:0] version_value,
  input  logic [axil_data_w-1:0] fatal_err_value,
  input  logic [axil_data_w-1:0] template_value,
  input  logic [axil_data_w-1:0] roce_low,
  input  logic [axil_data_w-1:0] roce_high,
  input  logic [axil_data_w-1:0] nonroce_low,
  input  logic [axil_data_w-1:0] nonroce_high,

  // One-cycle clear requests to the counters
  output logic                   clr_roce_low,
  output logic                   clr_roce_high,
  output logic                   clr_nonroce_low,
  output logic                   clr_nonroce_high
);

  rd_state_e              rd_state;
  logic [axil_data_w-1:0] rd_word;
  logic                   ar_fire;
  logic                   r_fire;

  // ==================================================================
  // Handshake decode
  // ==================================================================

  // One read in flight, address blocked until R completes
  assign s_axil_reg_arready = (rd_state == rd_idle);
  assign s_axil_reg_rvalid  = (rd_state == rd_resp);
  assign s_axil_reg_rresp   = axil_resp_okay;

  assign ar_fire = s_axil_reg_arvalid && s_axil_reg_arready;
  assign r_fire  = s_axil_reg_rvalid && s_axil_reg_rready;

  // Clear fires on the same edge that captures the old count
  assign clr_roce_low     = ar_fire && (s_axil_reg_araddr == reg_roce_low);
  assign clr_roce_high    = ar_fire && (s_axil_reg_araddr == reg_roce_high);
  assign clr_nonroce_low  = ar_fire && (s_axil_reg_araddr == reg_nonroce_low);
  assign clr_nonroce_high = ar_fire && (s_axil_reg_araddr == reg_nonroce_high);

  // ==================================================================
  // Address decode
  // ==================================================================

  always_comb
  begin
    case (s_axil_reg_araddr)
      reg_version:      rd_word = version_value;
      reg_fatal_err:    rd_word = fatal_err_value;
      reg_roce_high:    rd_word = roce_high;
      reg_roce_low:     rd_word = roce_low;
      reg_nonroce_high: rd_word = nonroce_high;
      reg_nonroce_low:  rd_word = nonroce_low;
      reg_template:     rd_word = template_value;
      // Unmapped offset
      default:          rd_word = default_value;
    endcase
  end

  // ==================================================================
  // Read FSM and data capture
  // ==================================================================

  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      rd_state <= rd_idle;
    end
    else
    begin
      case (rd_state)
        rd_idle:
        begin
          if (ar_fire)
          begin
            rd_state <= rd_resp;
          end
        end
        rd_resp:
        begin
          // Stay here under R back-pressure
          if (r_fire)
          begin
            rd_state <= rd_idle;
          end
        end
        default:
        begin
          rd_state <= rd_idle;
        end
      endcase
    end
  end

  // Data is frozen from AR handshake until R handshake
  always_ff @(posedge axil_aclk)
  begin
    if (ar_fire)
    begin
      s_axil_reg_rdata <= rd_word;
    end
  end

endmodule

// File: rn_pkt_counter.sv
// 64-bit packet counter kept as low and high words, each cleared on read
module rn_pkt_counter
  import rn_reg_pkg::*;
(
  input  logic                   axil_aclk,
  input  logic                   axil_arstn,

  // One pulse per received packet
  input  logic                   pkt_recved,

  // Clear requests from the read engine
  input  logic                   clr_low,
  input  logic                   clr_high,

  // Count words as seen by the host
  output logic [axil_data_w-1:0] cnt_low,
  output logic [axil_data_w-1:0] cnt_high
);

  logic low_wrap;

  // ==================================================================
  // Carry out of the low word
  // ==================================================================

  // Low word rolls over from all ones on this packet
  // No carry when the same edge clears it
  assign low_wrap = pkt_recved && !clr_low && (&cnt_low);

  // ==================================================================
  // Low word
  // ==================================================================

  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      cnt_low <= '0;
    end
    else if (clr_low)
    begin
      // Packet arriving with the clear is kept as the first count
      cnt_low <= {{(axil_data_w-1){1'b0}}, pkt_recved};
    end
    else if (pkt_recved)
    begin
      cnt_low <= cnt_low + axil_data_w'(1);
    end
  end

  // ==================================================================
  // High word
  // ==================================================================

  // Counts wraps of the low word, free to wrap itself
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      cnt_high <= '0;
    end
    else if (clr_high)
    begin
      // A wrap on the clearing edge still counts
      cnt_high <= {{(axil_data_w-1){1'b0}}, low_wrap};
    end
    else if (low_wrap)
    begin
      cnt_high <= cnt_high + axil_data_w'(1);
    end
  end

endmodule

// File: rn_reg_control.sv
// Receive statistics register block top with version and fatal-error registers
module rn_reg_control
  import rn_reg_pkg::*;
#(
  // Word returned for unmapped read offsets
  parameter logic [axil_data_w-1:0] default_value = 32'hDEEDBEEF,
  // Release tag in DDMMYYYY form
  parameter logic [axil_data_w-1:0] version_value = 32'h11082022
)(
  input  logic                   axil_aclk,
  input  logic                   axil_arstn,

  // AXI-Lite write side
  input  logic                   s_axil_reg_awvalid,
  input  logic [axil_addr_w-1:0] s_axil_reg_awaddr,
  output logic                   s_axil_reg_awready,
  input  logic                   s_axil_reg_wvalid,
  input  logic [axil_data_w-1:0] s_axil_reg_wdata,
  output logic                   s_axil_reg_wready,
  output logic                   s_axil_reg_bvalid,
  output logic [1:0]             s_axil_reg_bresp,
  input  logic                   s_axil_reg_bready,

  // AXI-Lite read side
  input  logic                   s_axil_reg_arvalid,
  input  logic [axil_addr_w-1:0] s_axil_reg_araddr,
  output logic                   s_axil_reg_arready,
  output logic                   s_axil_reg_rvalid,
  output logic [axil_data_w-1:0] s_axil_reg_rdata,
  output logic [1:0]             s_axil_reg_rresp,
  input  logic                   s_axil_reg_rready,

  // Packet filter status
  input  logic                   roce_pkt_recved,
  input  logic                   non_roce_pkt_recved,
  input  logic [axil_data_w-1:0] fatal_err
);

  logic [axil_data_w-1:0] version_reg;
  logic [axil_data_w-1:0] fatal_err_reg;
  logic [axil_data_w-1:0] template_value;
  logic [axil_data_w-1:0] roce_low;
  logic [axil_data_w-1:0] roce_high;
  logic [axil_data_w-1:0] nonroce_low;
  logic [axil_data_w-1:0] nonroce_high;
  logic                   clr_roce_low;
  logic                   clr_roce_high;
  logic                   clr_nonroce_low;
  logic                   clr_nonroce_high;

  // ==================================================================
  // Read-only registers
  // ==================================================================

  // Version word, loaded at reset and held
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      version_reg <= version_value;
    end
  end

  // Six filter error flags, sampled every cycle
  // Bit 0 flags filter FIFO full or RDMA back-pressure
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      fatal_err_reg <= '0;
    end
    else
    begin
      fatal_err_reg <= {{(axil_data_w-6){1'b0}}, fatal_err[5:0]};
    end
  end

  // ==================================================================
  // Bus engines
  // ==================================================================

  rn_axil_write u_axil_write (
    .axil_aclk          (axil_aclk),
    .axil_arstn         (axil_arstn),
    .s_axil_reg_awvalid (s_axil_reg_awvalid),
    .s_axil_reg_awaddr  (s_axil_reg_awaddr),
    .s_axil_reg_awready (s_axil_reg_awready),
    .s_axil_reg_wvalid  (s_axil_reg_wvalid),
    .s_axil_reg_wdata   (s_axil_reg_wdata),
    .s_axil_reg_wready  (s_axil_reg_wready),
    .s_axil_reg_bvalid  (s_axil_reg_bvalid),
    .s_axil_reg_bresp   (s_axil_reg_bresp),
    .s_axil_reg_bready  (s_axil_reg_bready),
    .template_value     (template_value)
  );

  rn_axil_read #(
    .default_value (default_value)
  ) u_axil_read (
    .axil_aclk          (axil_aclk),
    .axil_arstn         (axil_arstn),
    .s_axil_reg_arvalid (s_axil_reg_arvalid),
    .s_axil_reg_araddr  (s_axil_reg_araddr),
    .s_axil_reg_arready (s_axil_reg_arready),
    .s_axil_reg_rvalid  (s_axil_reg_rvalid),
    .s_axil_reg_rdata   (s_axil_reg_rdata),
    .s_axil_reg_rresp   (s_axil_reg_rresp),
    .s_axil_reg_rready  (s_axil_reg_rready),
    .version_value      (version_reg),
    .fatal_err_value    (fatal_err_reg),
    .template_value     (template_value),
    .roce_low           (roce_low),
    .roce_high          (roce_high),
    .nonroce_low        (nonroce_low),
    .nonroce_high       (nonroce_high),
    .clr_roce_low       (clr_roce_low),
    .clr_roce_high      (clr_roce_high),
    .clr_nonroce_low    (clr_nonroce_low),
    .clr_nonroce_high   (clr_nonroce_high)
  );

  // ==================================================================
  // Packet counters
  // ==================================================================

  // RoCEv2 traffic
  rn_pkt_counter u_roce_cnt (
    .axil_aclk  (axil_aclk),
    .axil_arstn (axil_arstn),
    .pkt_recved (roce_pkt_recved),
    .clr_low    (clr_roce_low),
    .clr_high   (clr_roce_high),
    .cnt_low    (roce_low),
    .cnt_high   (roce_high)
  );

  // Everything else the filter passes up
  rn_pkt_counter u_nonroce_cnt (
    .axil_aclk  (axil_aclk),
    .axil_arstn (axil_arstn),
    .pkt_recved (non_roce_pkt_recved),
    .clr_low    (clr_nonroce_low),
    .clr_high   (clr_nonroce_high),
    .cnt_low    (nonroce_low),
    .cnt_high   (nonroce_high)
  );

endmodule

// File: rn_reg_control_tb_tasks.svh
// AXI-Lite write and read tasks, packet and fatal drivers, value check and reference read model

// ==================================================================
// Check and reference model
// ==================================================================

// Mismatch report with time, name and both values
task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  n_checks++;
  if (got !== exp)
  begin
    n_errors++;
    $display("error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
  end
endtask

// Expected word for a read at this offset before any clear
function automatic logic [31:0] ref_read(input logic [axil_addr_w-1:0] addr);
  case (addr)
    reg_version:      return exp_version;
    reg_fatal_err:    return {26'd0, model_fatal[5:0]};
    reg_roce_high:    return model_roce_high;
    reg_roce_low:     return model_roce_low;
    reg_nonroce_high: return model_nonroce_high;
    reg_nonroce_low:  return model_nonroce_low;
    reg_template:     return model_template;
    default:          return exp_default;
  endcase
endfunction

// ==================================================================
// AXI-Lite master
// ==================================================================

// One write with AW and W together or W a few cycles late and a random B delay
task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data,
                          input logic together);
  int gap;
  int stall;
  gap = together ? 0 : int'($urandom_range(3, 1));
  stall = $urandom_range(4, 0);
  fork
    begin
      @(posedge axil_aclk);
      s_axil_reg_awvalid <= 1'b1;
      s_axil_reg_awaddr  <= addr;
      @(negedge axil_aclk);
      while (!s_axil_reg_awready)
      begin
        @(negedge axil_aclk);
      end
      @(posedge axil_aclk);
      s_axil_reg_awvalid <= 1'b0;
    end
    begin
      repeat (gap) @(posedge axil_aclk);
      @(posedge axil_aclk);
      s_axil_reg_wvalid <= 1'b1;
      s_axil_reg_wdata  <= data;
      @(negedge axil_aclk);
      while (!s_axil_reg_wready)
      begin
        @(negedge axil_aclk);
      end
      @(posedge axil_aclk);
      s_axil_reg_wvalid <= 1'b0;
    end
  join
  if (addr == reg_template)
  begin
    model_template = data;
  end
  @(negedge axil_aclk);
  while (!s_axil_reg_bvalid)
  begin
    @(negedge axil_aclk);
  end
  check("s_axil_reg_bresp", 32'(s_axil_reg_bresp), 32'(axil_resp_okay));
  // No second address is taken while B is held off
  repeat (stall)
  begin
    @(negedge axil_aclk);
    check("s_axil_reg_bvalid", 32'(s_axil_reg_bvalid), 32'd1);
    check("s_axil_reg_awready", 32'(s_axil_reg_awready), 32'd0);
  end
  @(posedge axil_aclk);
  s_axil_reg_bready <= 1'b1;
  @(posedge axil_aclk);
  s_axil_reg_bready <= 1'b0;
  @(negedge axil_aclk);
  check("s_axil_reg_awready", 32'(s_axil_reg_awready), 32'd1);
endtask

// One read with R stalled a random number of cycles and the data queued for compare
task automatic axil_read(input logic [axil_addr_w-1:0] addr, input int max_stall);
  int          stall;
  logic [31:0] first_data;
  stall = $urandom_range(max_stall, 0);
  @(posedge axil_aclk);
  s_axil_reg_arvalid <= 1'b1;
  s_axil_reg_araddr  <= addr;
  @(negedge axil_aclk);
  while (!s_axil_reg_arready)
  begin
    @(negedge axil_aclk);
  end
  @(posedge axil_aclk);
  s_axil_reg_arvalid <= 1'b0;
  @(negedge axil_aclk);
  check("s_axil_reg_rvalid", 32'(s_axil_reg_rvalid), 32'd1);
  check("s_axil_reg_rresp", 32'(s_axil_reg_rresp), 32'(axil_resp_okay));
  first_data = s_axil_reg_rdata;
  // R must hold steady under back-pressure
  repeat (stall)
  begin
    @(negedge axil_aclk);
    check("s_axil_reg_rvalid", 32'(s_axil_reg_rvalid), 32'd1);
    check("s_axil_reg_arready", 32'(s_axil_reg_arready), 32'd0);
    check("s_axil_reg_rdata", s_axil_reg_rdata, first_data);
  end
  @(posedge axil_aclk);
  s_axil_reg_rready <= 1'b1;
  @(posedge axil_aclk);
  s_axil_reg_rready <= 1'b0;
  rd_addr_q.push_back(addr);
  rd_data_q.push_back(first_data);
  ->rd_done;
  @(negedge axil_aclk);
  check("s_axil_reg_arready", 32'(s_axil_reg_arready), 32'd1);
endtask

// ==================================================================
// Packet filter side
// ==================================================================

// Random-spaced packet pulses on both inputs with the model updated afterwards
task automatic send_pkts(input int n_roce, input int n_nonroce);
  int   sent_roce;
  int   sent_nonroce;
  logic pulse_roce;
  logic pulse_nonroce;
  logic carry;
  sent_roce = 0;
  sent_nonroce = 0;
  while ((sent_roce < n_roce) || (sent_nonroce < n_nonroce))
  begin
    pulse_roce = (sent_roce < n_roce) && ($urandom_range(1, 0) == 1);
    pulse_nonroce = (sent_nonroce < n_nonroce) && ($urandom_range(1, 0) == 1);
    @(posedge axil_aclk);
    roce_pkt_recved     <= pulse_roce;
    non_roce_pkt_recved <= pulse_nonroce;
    if (pulse_roce)
    begin
      sent_roce++;
    end
    if (pulse_nonroce)
    begin
      sent_nonroce++;
    end
  end
  @(posedge axil_aclk);
  roce_pkt_recved     <= 1'b0;
  non_roce_pkt_recved <= 1'b0;
  // High word counts low-word wraps
  {carry, model_roce_low} = {1'b0, model_roce_low} + 33'(n_roce);
  model_roce_high = model_roce_high + 32'(carry);
  {carry, model_nonroce_low} = {1'b0, model_nonroce_low} + 33'(n_nonroce);
  model_nonroce_high = model_nonroce_high + 32'(carry);
endtask

// New fatal_err level on all 32 bits
task automatic drive_fatal(input logic [31:0] value);
  @(posedge axil_aclk);
  fatal_err <= value;
  model_fatal = value;
endtask

// File: rn_reg_control_tb.sv
// Testbench top with clock, reset, stimulus sequence, read scoreboard, watchdog and result line
module rn_reg_control_tb
  import rn_reg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // ==================================================================
  // Test constants
  // ==================================================================

  localparam logic [axil_data_w-1:0] exp_default = 32'hDEEDBEEF;
  localparam logic [axil_data_w-1:0] exp_version = 32'h11082022;

  // Unmapped offset inside the 4 KB window
  localparam logic [axil_addr_w-1:0] addr_unmapped = 12'h040;

  // Upper bound on reads, writes and packet bursts in the sequence below
  localparam int n_trans     = 32;
  localparam int watchdog_ns = 4 * 40 * n_trans;

  // ==================================================================
  // DUT signals
  // ==================================================================

  logic                   axil_aclk;
  logic                   axil_arstn;
  logic                   s_axil_reg_awvalid;
  logic [axil_addr_w-1:0] s_axil_reg_awaddr;
  logic                   s_axil_reg_awready;
  logic                   s_axil_reg_wvalid;
  logic [axil_data_w-1:0] s_axil_reg_wdata;
  logic                   s_axil_reg_wready;
  logic                   s_axil_reg_bvalid;
  logic [1:0]             s_axil_reg_bresp;
  logic                   s_axil_reg_bready;
  logic                   s_axil_reg_arvalid;
  logic [axil_addr_w-1:0] s_axil_reg_araddr;
  logic                   s_axil_reg_arready;
  logic                   s_axil_reg_rvalid;
  logic [axil_data_w-1:0] s_axil_reg_rdata;
  logic [1:0]             s_axil_reg_rresp;
  logic                   s_axil_reg_rready;
  logic                   roce_pkt_recved;
  logic                   non_roce_pkt_recved;
  logic [axil_data_w-1:0] fatal_err;

  // ==================================================================
  // Reference model state and scoreboard
  // ==================================================================

  // Template value, counts since the last read of each word, fatal input
  logic [axil_data_w-1:0] model_template;
  logic [axil_data_w-1:0] model_roce_low;
  logic [axil_data_w-1:0] model_roce_high;
  logic [axil_data_w-1:0] model_nonroce_low;
  logic [axil_data_w-1:0] model_nonroce_high;
  logic [axil_data_w-1:0] model_fatal;

  // Completed reads waiting for the compare process
  logic [axil_addr_w-1:0] rd_addr_q[$];
  logic [axil_data_w-1:0] rd_data_q[$];
  event                   rd_done;

  int n_checks;
  int n_errors;

  `include "rn_reg_control_tb_tasks.svh"

  rn_reg_control #(
    .default_value (exp_default),
    .version_value (exp_version)
  ) dut (
    .axil_aclk           (axil_aclk),
    .axil_arstn          (axil_arstn),
    .s_axil_reg_awvalid  (s_axil_reg_awvalid),
    .s_axil_reg_awaddr   (s_axil_reg_awaddr),
    .s_axil_reg_awready  (s_axil_reg_awready),
    .s_axil_reg_wvalid   (s_axil_reg_wvalid),
    .s_axil_reg_wdata    (s_axil_reg_wdata),
    .s_axil_reg_wready   (s_axil_reg_wready),
    .s_axil_reg_bvalid   (s_axil_reg_bvalid),
    .s_axil_reg_bresp    (s_axil_reg_bresp),
    .s_axil_reg_bready   (s_axil_reg_bready),
    .s_axil_reg_arvalid  (s_axil_reg_arvalid),
    .s_axil_reg_araddr   (s_axil_reg_araddr),
    .s_axil_reg_arready  (s_axil_reg_arready),
    .s_axil_reg_rvalid   (s_axil_reg_rvalid),
    .s_axil_reg_rdata    (s_axil_reg_rdata),
    .s_axil_reg_rresp    (s_axil_reg_rresp),
    .s_axil_reg_rready   (s_axil_reg_rready),
    .roce_pkt_recved     (roce_pkt_recved),
    .non_roce_pkt_recved (non_roce_pkt_recved),
    .fatal_err           (fatal_err)
  );

  // 4 ns clock
  initial
  begin
    axil_aclk = 1'b0;
    forever #2 axil_aclk = ~axil_aclk;
  end

  // Hang guard sized from the transaction count
  initial
  begin
    #(watchdog_ns);
    $display("timeout: tests still running after %0d ns", watchdog_ns);
    $display("Result: FAILED");
    $finish;
  end

  // ==================================================================
  // Compare process
  // ==================================================================

  initial
  begin
    logic [axil_addr_w-1:0] addr;
    logic [axil_data_w-1:0] data;
    forever
    begin
      @(rd_done);
      while (rd_addr_q.size() > 0)
      begin
        addr = rd_addr_q.pop_front();
        data = rd_data_q.pop_front();
        check("s_axil_reg_rdata", data, ref_read(addr));
        // Counter words start over once read
        case (addr)
          reg_roce_low:     model_roce_low = '0;
          reg_roce_high:    model_roce_high = '0;
          reg_nonroce_low:  model_nonroce_low = '0;
          reg_nonroce_high: model_nonroce_high = '0;
          default:          ;
        endcase
      end
    end
  end

  // ==================================================================
  // Stimulus sequence
  // ==================================================================

  initial
  begin
    int                     i;
    int                     n_roce;
    int                     n_nonroce;
    logic [axil_data_w-1:0] wdata;
    void'($urandom(32'h3ee1));
    n_checks = 0;
    n_errors = 0;
    model_template = '0;
    model_roce_low = '0;
    model_roce_high = '0;
    model_nonroce_low = '0;
    model_nonroce_high = '0;
    model_fatal = '0;
    axil_arstn <= 1'b0;
    s_axil_reg_awvalid <= 1'b0;
    s_axil_reg_awaddr <= '0;
    s_axil_reg_wvalid <= 1'b0;
    s_axil_reg_wdata <= '0;
    s_axil_reg_bready <= 1'b0;
    s_axil_reg_arvalid <= 1'b0;
    s_axil_reg_araddr <= '0;
    s_axil_reg_rready <= 1'b0;
    roce_pkt_recved <= 1'b0;
    non_roce_pkt_recved <= 1'b0;
    fatal_err <= '0;
    repeat (2) @(posedge axil_aclk);
    axil_arstn <= 1'b1;

    // Idle handshake levels out of reset and then the version word
    @(negedge axil_aclk);
    check("s_axil_reg_arready", 32'(s_axil_reg_arready), 32'd1);
    check("s_axil_reg_awready", 32'(s_axil_reg_awready), 32'd1);
    check("s_axil_reg_rvalid", 32'(s_axil_reg_rvalid), 32'd0);
    check("s_axil_reg_wready", 32'(s_axil_reg_wready), 32'd0);
    check("s_axil_reg_bvalid", 32'(s_axil_reg_bvalid), 32'd0);
    axil_read(reg_version, 3);

    // Template writes alternating AW with W and W after AW
    for (i = 0; i < 4; i++)
    begin
      wdata = $urandom();
      axil_write(reg_template, wdata, (i % 2) == 0);
      axil_read(reg_template, 4);
    end

    // Writes to read-only and unmapped offsets change nothing
    axil_write(reg_version, $urandom(), 1'b1);
    axil_write(addr_unmapped, $urandom(), 1'b0);
    axil_write(reg_roce_low, $urandom(), 1'b1);
    axil_read(reg_template, 2);
    axil_read(reg_version, 2);
    axil_read(reg_roce_low, 2);
    axil_read(reg_fatal_err, 2);

    // RoCE counter where the second low read sees the cleared word
    n_roce = $urandom_range(16, 1);
    send_pkts(n_roce, 0);
    axil_read(reg_roce_low, 3);
    axil_read(reg_roce_low, 3);
    axil_read(reg_roce_high, 3);

    // Both counters fed at once
    n_roce = $urandom_range(16, 1);
    n_nonroce = $urandom_range(16, 1);
    send_pkts(n_roce, n_nonroce);
    axil_read(reg_nonroce_low, 3);
    axil_read(reg_nonroce_low, 3);
    axil_read(reg_nonroce_high, 3);
    axil_read(reg_roce_low, 3);
    axil_read(reg_roce_high, 3);

    // Default word and fatal-error pass-through
    axil_read(addr_unmapped, 3);
    drive_fatal($urandom());
    axil_read(reg_fatal_err, 3);
    drive_fatal($urandom());
    axil_read(reg_fatal_err, 3);

    // Long R back-pressure
    axil_read(reg_template, 12);
    axil_read(reg_version, 12);

    @(posedge axil_aclk);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: rn_reg_control.f
+incdir+.
rn_reg_pkg.sv
rn_axil_write.sv
rn_axil_read.sv
rn_pkt_counter.sv
rn_reg_control.sv
rn_reg_control_tb.sv

// File: Makefile
TOP := rn_reg_control_tb

.PHONY: sim clean

sim:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module $(TOP) -f rn_reg_control.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
